// File: hw/vgaPkg.sv
// ======================================================================
// VGA screen definitions
// 640x480 frame limits, maze tile grid and 3-3-2 colour values
// ======================================================================
package vgaPkg;

	typedef logic [10:0] coordT;	// pixel coordinate on either axis

	// last visible pixel on each axis
	localparam coordT frameLastX = 11'd639;
	localparam coordT frameLastY = 11'd479;

	localparam int tileSize = 32;	// tile edge in pixels
	localparam int tileCols = 20;
	localparam int tileRows = 15;

	typedef logic [7:0] rgbT;	// {red[2:0], green[2:0], blue[1:0]}

	// yellow frame around the screen
	localparam rgbT borderColor = {3'b111, 3'b111, 2'b00};
	// plain floor between the walls
	localparam rgbT floorColor = {3'b101, 3'b101, 2'b10};

endpackage

// File: hw/mazePkg.sv
// ======================================================================
// Maze game definitions
// level encoding, maze and placement choices, tile grid coordinates
// ======================================================================
package mazePkg;

	typedef enum logic [1:0] {
		level1,
		level2,
		level3
	} levelT;

	typedef logic [1:0] mazeIdxT;	// 0 to 2
	typedef logic [2:0] placeIdxT;	// 0 to 4

	localparam int mazeChoices = 3;	// mazes per level
	localparam int placeChoices = 5;	// start position sets

	// position on the tile grid
	typedef logic [3:0] tileRowT;
	typedef logic [4:0] tileColT;

endpackage

// File: hw/mazeLookupIf.sv
// ======================================================================
// Maze lookup interface
// tile address and maze selection in, wall flag out, same cycle
// ======================================================================
`timescale 1ns/1ps

interface mazeLookupIf;
	import mazePkg::*;

	tileRowT tileRow;
	tileColT tileCol;
	levelT level;
	mazeIdxT mazeIdx;
	logic wallHit;	// addressed tile is a brick

	modport renderer (output tileRow, tileCol, input wallHit);
	modport setup (output level, mazeIdx);
	modport map (input tileRow, tileCol, level, mazeIdx, output wallHit);

endinterface

// File: hw/levelSetup.sv
// ======================================================================
// Level setup
// follows the level strobes, latches the maze and start set choice
// and publishes the start positions of savior, key and prison
// ======================================================================
`timescale 1ns/1ps

module levelSetup #(
	parameter int placeChoices = mazePkg::placeChoices
) (
	input logic clk,
	input logic resetN,
	input vgaPkg::coordT mazeSel,
	input logic startLevel2,
	input logic startLevel3,
	mazeLookupIf.setup lookup,
	output vgaPkg::coordT saviorX,
	output vgaPkg::coordT saviorY,
	output vgaPkg::coordT keyX,
	output vgaPkg::coordT keyY,
	output vgaPkg::coordT prisonX,
	output vgaPkg::coordT prisonY
);
	import vgaPkg::*;
	import mazePkg::*;

	// start positions per placement set
	localparam coordT saviorXTab [placeChoices] = '{11'h060, 11'h220, 11'h100, 11'h120, 11'h060};
	localparam coordT saviorYTab [placeChoices] = '{11'h160, 11'h0A0, 11'h0A0, 11'h180, 11'h080};
	localparam coordT keyXTab [placeChoices] = '{11'h180, 11'h0C0, 11'h1C0, 11'h040, 11'h200};
	localparam coordT keyYTab [placeChoices] = '{11'h160, 11'h060, 11'h140, 11'h0E0, 11'h080};
	localparam coordT prisonXTab [placeChoices] = '{11'h1A0, 11'h0C0, 11'h080, 11'h1C0, 11'h160};
	localparam coordT prisonYTab [placeChoices] = '{11'h060, 11'h180, 11'h060, 11'h080, 11'h100};

	levelT levelR;
	mazeIdxT mazeIdxR;
	placeIdxT placeIdxR;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			levelR <= level1;	// level 1 always plays maze 0 with set 0
			mazeIdxR <= '0;
			placeIdxR <= '0;
		end else if (startLevel2 || startLevel3) begin
			levelR <= startLevel3 ? level3 : level2;
			mazeIdxR <= mazeIdxT'(mazeSel % mazeChoices);
			placeIdxR <= placeIdxT'(mazeSel % placeChoices);
		end
	end

	assign lookup.level = levelR;
	assign lookup.mazeIdx = mazeIdxR;

	assign saviorX = saviorXTab[placeIdxR];
	assign saviorY = saviorYTab[placeIdxR];
	assign keyX = keyXTab[placeIdxR];
	assign keyY = keyYTab[placeIdxR];
	assign prisonX = prisonXTab[placeIdxR];
	assign prisonY = prisonYTab[placeIdxR];

	// game control raises one level start at a time
	a_oneStrobe: assert property (@(posedge clk) disable iff (!resetN)
		!(startLevel2 && startLevel3));

	// both tables are addressed inside their range
	a_idxRange: assert property (@(posedge clk) disable iff (!resetN)
		(mazeIdxR < mazeChoices) && (placeIdxR < placeChoices));

endmodule

// File: hw/mazeMap.sv
// ======================================================================
// Maze wall map
// nine 15x20 wall tables, three per level, and the tile lookup
// ======================================================================
`timescale 1ns/1ps

module mazeMap (
	mazeLookupIf.map lookup
);
	import vgaPkg::*;
	import mazePkg::*;

	localparam int levelCount = 3;
	localparam int mapCount = levelCount * mazeChoices;

	typedef logic [0:tileCols-1] wallRowT;	// column 0 is the leftmost bit

	// one bit per tile, 1 is a brick
	localparam wallRowT mazeRom [mapCount][tileRows] = '{
		// level 1 maze 0
		'{20'b00000_00000_00000_00000, 20'b00000_00000_00000_00000,
		  20'b01111_11110_11111_11110, 20'b01010_00010_10000_00010,
		  20'b01000_00011_10000_00010, 20'b01000_00000_00000_00010,
		  20'b01000_01000_00001_00010, 20'b01000_01000_00001_00010,
		  20'b01000_01111_10011_10010, 20'b01110_00000_10000_00010,
		  20'b01000_00000_10000_00110, 20'b01000_00000_00000_01110,
		  20'b01000_00000_00000_11110, 20'b01111_11111_11111_11110,
		  20'b00000_00000_00000_00000},
		// level 1 maze 1
		'{20'b00000_00000_00000_00000, 20'b00000_00000_00000_00000,
		  20'b01111_11111_11111_11110, 20'b01010_00000_01000_00010,
		  20'b01000_00000_01000_00010, 20'b01000_00000_01000_00010,
		  20'b01000_10000_01000_00010, 20'b01000_10000_00000_00010,
		  20'b01000_10000_00000_00010, 20'b01000_10000_00001_11110,
		  20'b01000_11100_00000_00010, 20'b01000_00000_00000_00010,
		  20'b01000_00000_00000_00010, 20'b01111_11111_11111_11110,
		  20'b00000_00000_00000_00000},
		// level 1 maze 2
		'{20'b00000_00000_00000_00000, 20'b00000_00000_00000_00000,
		  20'b01111_11110_01111_11110, 20'b01000_00010_01000_00010,
		  20'b01000_00011_11000_00010, 20'b01110_00000_00000_00010,
		  20'b01000_00000_00000_00010, 20'b01000_00111_10000_00010,
		  20'b01000_00100_10000_00010, 20'b01111_00100_10011_11110,
		  20'b01001_00000_10000_01000, 20'b01000_00000_00000_01000,
		  20'b01000_00000_00011_11000, 20'b01111_11111_11110_00000,
		  20'b00000_00000_00000_00000},
		// level 2 maze 0
		'{20'b00000_00000_00000_00000, 20'b00000_00000_00000_00000,
		  20'b00111_11110_11111_11110, 20'b11110_00010_10000_00010,
		  20'b10000_00011_10000_00010, 20'b10000_00000_00011_00011,
		  20'b10001_11000_00001_00001, 20'b01000_00000_10001_00001,
		  20'b11000_00000_10000_00111, 20'b10001_11111_10000_00001,
		  20'b10001_00010_00000_00001, 20'b10001_00000_00000_00010,
		  20'b01001_00000_00000_00010, 20'b01111_11111_11111_11110,
		  20'b00000_00000_00000_00000},
		// level 2 maze 1
		'{20'b00000_00000_00000_00000, 20'b00000_00000_00000_00000,
		  20'b00111_11111_11111_11110, 20'b11110_00000_00000_00010,
		  20'b10000_00000_00000_00010, 20'b10000_00000_00011_00011,
		  20'b10000_11000_10001_00001, 20'b01001_00000_10000_00001,
		  20'b11001_00000_10000_00011, 20'b10001_11100_11111_10001,
		  20'b10000_10000_00001_00001, 20'b10000_00000_00000_00001,
		  20'b01000_00001_00000_00001, 20'b01111_11111_11111_11110,
		  20'b00000_00000_00000_00000},
		// level 2 maze 2
		'{20'b00000_00000_00000_00000, 20'b00000_00000_00000_00000,
		  20'b01111_11111_11111_11110, 20'b01010_00010_10000_00010,
		  20'b01000_00000_00000_00010, 20'b01000_00000_00010_00010,
		  20'b01000_11000_00001_00010, 20'b10000_11000_00001_10010,
		  20'b10000_01111_10011_00010, 20'b10000_00100_10000_00010,
		  20'b11000_00100_00000_00110, 20'b11100_00000_00000_01110,
		  20'b11110_00000_10000_11110, 20'b11111_11111_11111_11110,
		  20'b00000_00000_00000_00000},
		// level 3 maze 0
		'{20'b00000_00000_00000_00000, 20'b00000_00000_00000_00000,
		  20'b01111_11100_01111_11110, 20'b01000_00010_01000_10010,
		  20'b01000_00011_11000_00011, 20'b01110_00000_00000_00001,
		  20'b01000_00000_00000_10001, 20'b01000_00111_11100_11001,
		  20'b01000_00011_00100_01011, 20'b01111_00001_00100_01110,
		  20'b01001_00111_00000_00010, 20'b01000_00100_00000_00010,
		  20'b01000_00000_00010_00110, 20'b01100_00000_01011_11100,
		  20'b00011_11111_11110_00000},
		// level 3 maze 1
		'{20'b00000_00000_00000_00000, 20'b00000_00000_00000_00000,
		  20'b11111_11111_11111_11110, 20'b11001_00010_01000_00010,
		  20'b10000_00010_01000_00010, 20'b10000_00000_01110_00010,
		  20'b11000_10000_01100_00011, 20'b11001_10000_00000_10001,
		  20'b11000_10010_00000_10001, 20'b11100_10010_00001_11111,
		  20'b11111_11111_00000_00001, 20'b11000_00000_00000_00001,
		  20'b11000_00000_00000_00001, 20'b11100_00111_11000_01111,
		  20'b11111_11000_00111_11111},
		// level 3 maze 2
		'{20'b00000_00000_00000_00000, 20'b00000_00000_00000_00000,
		  20'b01111_11111_11111_11100, 20'b01010_00000_10000_00011,
		  20'b01000_00000_10000_00001, 20'b01000_01000_11000_01001,
		  20'b11000_01000_00001_01001, 20'b10001_11000_00001_11011,
		  20'b10000_01111_10000_00011, 20'b11100_01000_10000_00011,
		  20'b10000_01000_11100_00111, 20'b10000_00000_00010_01111,
		  20'b10000_00000_00000_01111, 20'b01111_11111_00000_01111,
		  20'b01010_10101_11111_11111}
	};

	logic [3:0] mapSel;	// level major, maze minor
	logic inRange;

	assign mapSel = 4'(int'(lookup.level) * mazeChoices + int'(lookup.mazeIdx));

	// off-grid tiles and unused maze codes read as floor
	assign inRange = (mapSel < mapCount) && (lookup.tileRow < tileRows) &&
		(lookup.tileCol < tileCols);

	assign lookup.wallHit = inRange ? mazeRom[mapSel][lookup.tileRow][lookup.tileCol] : 1'b0;

endmodule

// File: hw/brickTexture.sv
// ======================================================================
// Brick texture
// 32x32 texel ROM in 3-3-2 colour, read combinationally
// ======================================================================
`timescale 1ns/1ps

module brickTexture #(
	parameter int tileSize = vgaPkg::tileSize
) (
	input logic [$clog2(tileSize)-1:0] texelRow,
	input logic [$clog2(tileSize)-1:0] texelCol,
	output vgaPkg::rgbT texel
);
	import vgaPkg::*;

	// one row per line, leftmost byte is column 0
	localparam rgbT [0:tileSize-1] brickRom [tileSize] = '{
		256'hB2880000_00000000_00000000_00000000_00000000_00000000_00000000_000000B2,
		256'hB1FF0000_00000000_00000000_000000FF_FF000000_00000000_00000000_0000FFB1,
		256'hB1FF0000_00000000_00000000_000000FF_FF000000_00000000_00000000_0000FFB1,
		256'hB1FF0000_00000000_00000000_000000FF_FF000000_00000000_00000000_0000FFB1,
		256'hB2880000_00000000_00000000_000000FF_FF000000_00000000_00000000_0000FFB2,
		256'hB2880000_00000000_00000000_000000FF_FF000000_00000000_00000000_0000FFB2,
		256'hB100FFFF_00FFFFFF_FFFFFFFF_FFFF00FF_FF00FFFF_FF000000_00FF0000_00FF00B1,
		256'hB2FFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFDB,
		256'hDBFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFDB,
		256'hDB69FFFF_FFFFFFFF_FF48FFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFF69DB,
		256'hD6FFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFF00FF_FFFFFFFF_FFFFFFB2,
		256'hB1FF0000_000000FF_FFFF0000_00000000_00000000_0000FFFF_FF000000_0000FFB1,
		256'hB1FF0000_000000FF_FFFF0000_00000000_00000000_0000FFFF_FF000000_0000FFB1,
		256'hB1FF0000_000000FF_FF000000_00000000_00000000_0000FFFF_FF000000_0000FFB1,
		256'hB2FF0000_000000FF_FF000000_00000000_00000000_0000FFFF_FF000000_0000FFB2,
		256'hB2FF0000_000000FF_FF000000_00000000_00000000_0000FFFF_FF000000_0000FFB1,
		256'hB1FF0000_000000FF_FF000000_00000000_00000000_0000FFFF_FF000000_0000FFB1,
		256'hB1FF0000_000000FF_FF000000_00000000_00000000_0000FFFF_FF000000_0000FFB1,
		256'hB2FF0000_000000FF_FF000000_00000000_00000000_0000FFFF_FF000000_0000FFB2,
		256'hB2FF0000_000000FF_FFFF0000_00000000_00000000_0000FFFF_FF000000_0000FFB2,
		256'hB200FFFF_FFFFFFFF_FF00FFFF_FF00FFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFF00B2,
		256'hB2FFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFB2,
		256'hDBFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFDB,
		256'hFB69FFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFF69DB,
		256'hD6FFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFB2,
		256'hB2FF0000_00000000_00000000_000000FF_FF000000_00000000_00000000_0000FFB2,
		256'hB1FF0000_00000000_00000000_000000FF_FF000000_00000000_00000000_0000FFB1,
		256'hB1FF0000_00000000_00000000_000000FF_FF000000_00000000_00000000_0000FFB1,
		256'hB2FF0000_00000000_00000000_000000FF_FF000000_00000000_00000000_0000FFB2,
		256'hB2880000_00000000_00000000_000000FF_FF000000_00000000_00000000_0000FFDB,
		256'hB2880000_00000000_00000000_000000FF_FF000000_00000000_00000000_0000FFB1,
		256'hB1880000_00000000_00000000_00000000_00000000_00000000_00000000_000000B1
	};

	assign texel = brickRom[texelRow][texelCol];

endmodule

// File: hw/backgroundRenderer.sv
// ======================================================================
// Background renderer
// splits the pixel into tile and texel, picks border, brick or floor
// and registers the colour with the wall flag
// ======================================================================
`timescale 1ns/1ps

module backgroundRenderer #(
	parameter int tileSize = vgaPkg::tileSize
) (
	input logic clk,
	input logic resetN,
	input vgaPkg::coordT pixelX,
	input vgaPkg::coordT pixelY,
	mazeLookupIf.renderer lookup,
	output logic [$clog2(tileSize)-1:0] texelRow,
	output logic [$clog2(tileSize)-1:0] texelCol,
	input vgaPkg::rgbT texel,
	output vgaPkg::rgbT bgRgb,
	output logic wallDrawReq
);
	import vgaPkg::*;
	import mazePkg::*;

	localparam int texelBits = $clog2(tileSize);

	logic onEdge;

	// tile index from the upper bits, texel from the lower ones
	assign lookup.tileRow = tileRowT'(pixelY / tileSize);
	assign lookup.tileCol = tileColT'(pixelX / tileSize);
	assign texelRow = pixelY[texelBits-1:0];
	assign texelCol = pixelX[texelBits-1:0];

	assign onEdge = (pixelX == '0) || (pixelY == '0) ||
		(pixelX == frameLastX) || (pixelY == frameLastY);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			bgRgb <= '0;
			wallDrawReq <= 1'b0;
		end else if (onEdge) begin
			bgRgb <= borderColor;	// frame beats any wall
			wallDrawReq <= 1'b0;
		end else if (lookup.wallHit) begin
			bgRgb <= texel;
			wallDrawReq <= 1'b1;
		end else begin
			bgRgb <= floorColor;
			wallDrawReq <= 1'b0;
		end
	end

	// no wall request for a frame pixel, one clock later
	a_noWallOnEdge: assert property (@(posedge clk) disable iff (!resetN)
		onEdge |=> !wallDrawReq);

endmodule

// File: hw/mazeBackground.sv
// ======================================================================
// Maze background layer
// colour and wall flag per pixel, one clock after the coordinate
// ======================================================================
`timescale 1ns/1ps

module mazeBackground #(
	parameter int tileSize = vgaPkg::tileSize,
	parameter int placeChoices = mazePkg::placeChoices
) (
	input logic clk,
	input logic resetN,
	input vgaPkg::coordT pixelX,
	input vgaPkg::coordT pixelY,
	input vgaPkg::coordT mazeSel,
	input logic startLevel2,
	input logic startLevel3,
	output vgaPkg::rgbT bgRgb,
	output logic wallDrawReq,
	output vgaPkg::coordT saviorX,
	output vgaPkg::coordT saviorY,
	output vgaPkg::coordT keyX,
	output vgaPkg::coordT keyY,
	output vgaPkg::coordT prisonX,
	output vgaPkg::coordT prisonY
);
	import vgaPkg::*;

	logic [$clog2(tileSize)-1:0] texelRow;
	logic [$clog2(tileSize)-1:0] texelCol;
	rgbT texel;

	mazeLookupIf lookup ();

	levelSetup #(.placeChoices(placeChoices)) u_levelSetup (
		.clk(clk), .resetN(resetN), .mazeSel(mazeSel),
		.startLevel2(startLevel2), .startLevel3(startLevel3), .lookup(lookup.setup),
		.saviorX(saviorX), .saviorY(saviorY), .keyX(keyX), .keyY(keyY),
		.prisonX(prisonX), .prisonY(prisonY)
	);

	mazeMap u_mazeMap (.lookup(lookup.map));

	brickTexture #(.tileSize(tileSize)) u_brickTexture (
		.texelRow(texelRow), .texelCol(texelCol), .texel(texel)
	);

	backgroundRenderer #(.tileSize(tileSize)) u_backgroundRenderer (
		.clk(clk), .resetN(resetN), .pixelX(pixelX), .pixelY(pixelY),
		.lookup(lookup.renderer), .texelRow(texelRow), .texelCol(texelCol),
		.texel(texel), .bgRgb(bgRgb), .wallDrawReq(wallDrawReq)
	);

endmodule

// File: test/mazeBackgroundTb.sv
// ======================================================================
// Maze background testbench
// table-driven checks of frame, floor rows, wall row, start positions
// and level changes, one pixel per step with one clock latency
// ======================================================================
`timescale 1ns/1ps

module mazeBackgroundTb;
	import vgaPkg::*;

	localparam logic [7:0] yellow = {3'b111, 3'b111, 2'b00};
	localparam logic [7:0] floorRgb = {3'b101, 3'b101, 2'b10};
	localparam logic [7:0] brickLine = 8'hFF;	// texel row 7 of the brick

	// start positions by placement set
	localparam coordT saviorXSet [5] = '{11'h060, 11'h220, 11'h100, 11'h120, 11'h060};
	localparam coordT saviorYSet [5] = '{11'h160, 11'h0A0, 11'h0A0, 11'h180, 11'h080};
	localparam coordT keyXSet [5] = '{11'h180, 11'h0C0, 11'h1C0, 11'h040, 11'h200};
	localparam coordT keyYSet [5] = '{11'h160, 11'h060, 11'h140, 11'h0E0, 11'h080};
	localparam coordT prisonXSet [5] = '{11'h1A0, 11'h0C0, 11'h080, 11'h1C0, 11'h160};
	localparam coordT prisonYSet [5] = '{11'h060, 11'h180, 11'h060, 11'h080, 11'h100};

	typedef struct packed {
		logic [7:0] testIdx;
		logic [1:0] strobe;	// bit 0 level 2, bit 1 level 3
		coordT sel;
		coordT x;
		coordT y;
		logic [7:0] rgb;
		logic wall;
		logic [2:0] set;	// expected placement set
		logic [1:0] level;	// expected level code
	} stepT;

	logic clk;
	logic resetN;
	coordT pixelX, pixelY, mazeSel;
	logic startLevel2, startLevel3;
	rgbT bgRgb;
	logic wallDrawReq;
	coordT saviorX, saviorY, keyX, keyY, prisonX, prisonY;

	stepT steps [$];
	string testNames [$];
	int curTest;
	logic [1:0] expLevel;
	int expSet;
	coordT curSel;
	bit tableReady = 1'b0;
	int totalChecks, totalErrors, testChecks, testErrors;

	mazeBackground u_mazeBackground (
		.clk(clk), .resetN(resetN), .pixelX(pixelX), .pixelY(pixelY),
		.mazeSel(mazeSel), .startLevel2(startLevel2), .startLevel3(startLevel3),
		.bgRgb(bgRgb), .wallDrawReq(wallDrawReq),
		.saviorX(saviorX), .saviorY(saviorY), .keyX(keyX), .keyY(keyY),
		.prisonX(prisonX), .prisonY(prisonY)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		totalChecks++;
		testChecks++;
		if (got !== exp) begin
			totalErrors++;
			testErrors++;
			$display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic beginTest(input string name);
		testNames.push_back(name);
		curTest = testNames.size() - 1;
	endtask

	task automatic pushStep(input logic [1:0] strobe, input coordT x, input coordT y,
		input logic [7:0] rgb, input logic wall);
		stepT s;
		s.testIdx = 8'(curTest);
		s.strobe = strobe;
		s.sel = (strobe != 2'b00) ? curSel : curSel + 11'd1;	// only latched on a strobe
		s.x = x;
		s.y = y;
		s.rgb = rgb;
		s.wall = wall;
		s.set = 3'(expSet);
		s.level = expLevel;
		steps.push_back(s);
	endtask

	task automatic frameEdges();
		pushStep(2'b00, 11'd0, 11'd240, yellow, 1'b0);	// left
		pushStep(2'b00, 11'd639, 11'd240, yellow, 1'b0);	// right
		pushStep(2'b00, 11'd320, 11'd0, yellow, 1'b0);
		pushStep(2'b00, 11'd320, 11'd479, yellow, 1'b0);
	endtask

	// tile rows 0 and 1 are free in every maze
	task automatic floorRows(input int count);
		coordT x;
		for (int i = 0; i < count; i++) begin
			x = 11'(1 + ($urandom % 638));
			pushStep(2'b00, x, (i % 2) ? 11'd48 : 11'd17, floorRgb, 1'b0);
		end
	endtask

	// tile row 13, texel row 7, texel column 1
	task automatic wallRow();
		for (int c = 1; c <= 13; c++)
			pushStep(2'b00, 11'(32 * c + 1), 11'd423, brickLine, 1'b1);
	endtask

	// strobe goes with an edge pixel, so the old maze never shows
	task automatic levelStart(input int level, input coordT sel);
		curSel = sel;
		expLevel = (level == 3) ? 2'd2 : 2'd1;
		expSet = sel % 5;
		pushStep((level == 3) ? 2'b10 : 2'b01, 11'd0, 11'd100, yellow, 1'b0);
	endtask

	initial begin
		stepT s;
		int t;
		coordT level2Sels [3] = '{11'd7, 11'd9, 11'd11};
		void'($urandom(32'h7b55));
		resetN = 1'b0;
		pixelX = '0;
		pixelY = '0;
		mazeSel = '0;
		startLevel2 = 1'b0;
		startLevel3 = 1'b0;
		curSel = '0;
		expLevel = 2'd0;
		expSet = 0;

		beginTest("level 1 frame and start set");
		frameEdges();
		beginTest("level 1 floor rows");
		floorRows(8);
		beginTest("level 1 wall row");
		wallRow();
		foreach (level2Sels[k]) begin
			beginTest($sformatf("level 2 with mazeSel %0d", level2Sels[k]));
			levelStart(2, level2Sels[k]);
			frameEdges();
			floorRows(6);
			wallRow();
		end
		beginTest("level 3 frame, floor, start set");
		levelStart(3, 11'($urandom % 2048));
		frameEdges();
		floorRows(6);
		tableReady = 1'b1;

		repeat (2) @(posedge clk);
		@(negedge clk);
		testChecks = 0;
		testErrors = 0;
		checkValue("bgRgb", bgRgb, 8'h00);
		checkValue("wallDrawReq", wallDrawReq, 1'b0);
		$display("%-34s %0d checks, %0d errors", "reset state", testChecks, testErrors);
		resetN = 1'b1;

		testChecks = 0;
		testErrors = 0;
		for (int i = 0; i < steps.size(); i++) begin
			s = steps[i];
			@(negedge clk);
			pixelX = s.x;
			pixelY = s.y;
			mazeSel = s.sel;
			startLevel2 = s.strobe[0];
			startLevel3 = s.strobe[1];
			@(negedge clk);
			startLevel2 = 1'b0;
			startLevel3 = 1'b0;
			checkValue("bgRgb", bgRgb, s.rgb);
			checkValue("wallDrawReq", wallDrawReq, s.wall);
			checkValue("saviorX", saviorX, saviorXSet[s.set]);
			checkValue("saviorY", saviorY, saviorYSet[s.set]);
			checkValue("keyX", keyX, keyXSet[s.set]);
			checkValue("keyY", keyY, keyYSet[s.set]);
			checkValue("prisonX", prisonX, prisonXSet[s.set]);
			checkValue("prisonY", prisonY, prisonYSet[s.set]);
			checkValue("level", 32'(u_mazeBackground.lookup.level), 32'(s.level));
			if (i == steps.size() - 1 || steps[i + 1].testIdx != s.testIdx) begin
				t = s.testIdx;
				$display("%-34s %0d checks, %0d errors", testNames[t], testChecks, testErrors);
				testChecks = 0;
				testErrors = 0;
			end
		end

		$display("%0d tests, %0d checks, %0d errors", testNames.size() + 1, totalChecks,
			totalErrors);
		if (totalErrors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// two clocks per step, reset and slack in the fixed part
	initial begin
		wait (tableReady);
		repeat (steps.size() * 4 + 100) @(posedge clk);
		$display("timeout: the step table did not finish in time");
		$display("Test failed");
		$finish;
	end

endmodule

// File: tb.f
hw/vgaPkg.sv
hw/mazePkg.sv
hw/mazeLookupIf.sv
hw/levelSetup.sv
hw/mazeMap.sv
hw/brickTexture.sv
hw/backgroundRenderer.sv
hw/mazeBackground.sv
test/mazeBackgroundTb.sv

// File: Bender.yml
package:
  name: maze_background

sources:
  - files:
      - hw/vgaPkg.sv
      - hw/mazePkg.sv
      - hw/mazeLookupIf.sv
      - hw/levelSetup.sv
      - hw/mazeMap.sv
      - hw/brickTexture.sv
      - hw/backgroundRenderer.sv
      - hw/mazeBackground.sv
  - target: test
    files:
      - test/mazeBackgroundTb.sv
